/* hw/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Bus widths
`define ICACHE_AW          32
`define ICACHE_DW          32

// Cache geometry
`define ICACHE_LINES       16          // Fully associative, FIFO replaced
`define ICACHE_LINE_WORDS  32          // One burst per line
`define ICACHE_TAG_LSB     7           // Above word select [6:2] and byte offset [1:0]
`define ICACHE_TAG_MSB     26          // Bits [31:27] not compared

// Derived widths
`define ICACHE_TAG_W       (`ICACHE_TAG_MSB - `ICACHE_TAG_LSB + 1)
`define ICACHE_IDX_W       ($clog2(`ICACHE_LINES))
`define ICACHE_WORD_W      ($clog2(`ICACHE_LINE_WORDS))
`define ICACHE_RAM_AW      (`ICACHE_IDX_W + `ICACHE_WORD_W)
`define ICACHE_BL_W        10          // Bus burst length field

`endif

/* hw/icache_pkg.sv */
`include "icache_config.svh"

package icache_pkg;

    // Access width, encoded as on the CPU fetch port
    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'b00,
        WIDTH_HALF = 2'b01,
        WIDTH_WORD = 2'b10
    } width_e;

    typedef struct packed {
        logic [`ICACHE_AW-1:0]   addr;    // Byte address
        width_e                  width;
    } cpu_req_t;

    typedef struct packed {
        logic                    valid;   // One-cycle pulse
        logic [`ICACHE_DW-1:0]   data;    // Right-aligned, zero-filled
    } cpu_rsp_t;

    // ------------------------------------------------------------------------
    // Burst bus and internal storage
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                    stb;     // High for the whole burst
        logic [`ICACHE_AW-1:0]   adr;     // Line base
        logic [`ICACHE_BL_W-1:0] bl;      // Words in burst
    } wb_req_t;

    typedef struct packed {
        logic                    ack;     // Data word valid
        logic                    lack;    // Last word of burst
        logic [`ICACHE_DW-1:0]   dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                    valid;
        logic [`ICACHE_TAG_W-1:0] tag;    // Address bits [26:7]
    } tag_entry_t;

    typedef struct packed {
        logic                    en;
        logic [`ICACHE_RAM_AW-1:0] addr;  // {line index, word index}
        logic [`ICACHE_DW-1:0]   data;
    } ram_wr_t;

endpackage

/* hw/icache_data_ram.sv */
`include "icache_config.svh"

module icache_data_ram (
    input  logic                      mclk,

    input  icache_pkg::ram_wr_t       wr_i,       // Refill side
    input  logic                      rd_en_i,    // Lookup side
    input  logic [`ICACHE_RAM_AW-1:0] rd_addr_i,
    output logic [`ICACHE_DW-1:0]     rd_data_o
);

    // 16 lines x 32 words
    logic [`ICACHE_DW-1:0] mem [`ICACHE_LINES*`ICACHE_LINE_WORDS];

    always_ff @(posedge mclk) begin
        if (wr_i.en) begin
            mem[wr_i.addr] <= wr_i.data;
        end
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];    // Held until next read
        end
    end

endmodule

/* hw/icache_tag_store.sv */
`include "icache_config.svh"

module icache_tag_store (
    input  logic                     mclk,
    input  logic                     rst_n,

    input  logic [`ICACHE_TAG_W-1:0] cmp_tag_i,
    output logic                     hit_o,
    output logic [`ICACHE_IDX_W-1:0] hindex_o,

    input  logic                     wr_i,        // Refill complete
    input  icache_pkg::tag_entry_t   wr_entry_i,
    output logic [`ICACHE_IDX_W-1:0] wr_ptr_o     // FIFO replacement pointer
);

    localparam int IDX_W = `ICACHE_IDX_W;

    icache_pkg::tag_entry_t    tags [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]  hit_vec;            // One-hot match
    logic [IDX_W-1:0]          wr_ptr_q;

    // Parallel compare against every valid entry
    always_comb begin
        hit_vec  = '0;
        hindex_o = '0;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            if (tags[i].valid && (tags[i].tag == cmp_tag_i)) begin
                hit_vec[i] = 1'b1;
                hindex_o   = IDX_W'(i);     // At most one entry matches
            end
        end
    end

    assign hit_o    = |hit_vec;
    assign wr_ptr_o = wr_ptr_q;

    // Write at the pointer, pointer wraps after the last line
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                tags[i] <= '0;              // All lines invalid
            end
        end else if (wr_i) begin
            tags[wr_ptr_q] <= wr_entry_i;
            wr_ptr_q       <= wr_ptr_q + 1'b1;
        end
    end

endmodule

/* hw/icache_refill.sv */
`include "icache_config.svh"

module icache_refill (
    input  logic                     mclk,
    input  logic                     rst_n,

    input  logic                     start_i,      // One-cycle pulse from controller
    input  logic [`ICACHE_AW-1:0]    line_addr_i,  // Line base
    input  logic [`ICACHE_IDX_W-1:0] wr_ptr_i,     // Line being replaced

    output icache_pkg::wb_req_t      wb_req_o,
    input  icache_pkg::wb_rsp_t      wb_rsp_i,

    output icache_pkg::ram_wr_t      ram_wr_o,
    output logic                     tag_wr_o,
    output icache_pkg::tag_entry_t   tag_entry_o,
    output logic                     done_o
);

    logic                      stb_q;
    logic [`ICACHE_AW-1:0]     line_q;
    logic [`ICACHE_WORD_W-1:0] word_cnt;      // Next word within the line
    logic                      word_ack;
    logic                      last_ack;

    assign word_ack = stb_q && wb_rsp_i.ack;
    assign last_ack = word_ack && wb_rsp_i.lack;

    assign wb_req_o = '{stb: stb_q, adr: line_q, bl: `ICACHE_BL_W'(`ICACHE_LINE_WORDS)};

    // Each acked word goes straight into RAM
    assign ram_wr_o = '{en: word_ack, addr: {wr_ptr_i, word_cnt}, data: wb_rsp_i.dat};

    // Tag entry lands with the last word, pointer moves on after it
    assign tag_wr_o    = last_ack;
    assign tag_entry_o = '{valid: 1'b1, tag: line_q[`ICACHE_TAG_MSB:`ICACHE_TAG_LSB]};

    // ------------------------------------------------------------------------
    // Burst control
    // ------------------------------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            stb_q    <= 1'b0;
            word_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= last_ack;             // One cycle behind tag write
            if (start_i) begin
                stb_q    <= 1'b1;
                word_cnt <= '0;
            end else if (word_ack) begin
                word_cnt <= word_cnt + 1'b1;
                if (wb_rsp_i.lack) stb_q <= 1'b0;    // Drops after last ack
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (start_i) line_q <= line_addr_i;
    end

endmodule

/* hw/icache_ctrl.sv */
`include "icache_config.svh"

module icache_ctrl (
    input  logic                      mclk,
    input  logic                      rst_n,

    input  logic                      cpu_req_valid_i,
    input  icache_pkg::cpu_req_t      cpu_req_i,
    output logic                      cpu_req_ack_o,
    output icache_pkg::cpu_rsp_t      cpu_rsp_o,

    output logic [`ICACHE_TAG_W-1:0]  cmp_tag_o,
    input  logic                      tag_hit_i,
    input  logic [`ICACHE_IDX_W-1:0]  tag_hindex_i,

    output logic                      refill_start_o,
    output logic [`ICACHE_AW-1:0]     refill_addr_o,
    input  logic                      refill_done_i,

    output logic                      ram_rd_en_o,
    output logic [`ICACHE_RAM_AW-1:0] ram_rd_addr_o,
    input  logic [`ICACHE_DW-1:0]     ram_rd_data_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,     // Tag compare, RAM read or refill start
        S_REFILL,     // Waiting on burst engine
        S_READ,       // RAM word available, aligned here
        S_RESPOND     // Response pulse registered on exit
    } state_e;

    state_e                   state;
    icache_pkg::cpu_req_t     req_q;          // Request held for the whole access
    logic                     rsp_valid_q;
    logic [`ICACHE_DW-1:0]    rsp_data_q;

    // Pick byte or halfword by offset, upper bits forced to zero
    function automatic logic [`ICACHE_DW-1:0] align_rdata(
        input icache_pkg::width_e    width,
        input logic [1:0]            offset,
        input logic [`ICACHE_DW-1:0] word
    );
        logic [`ICACHE_DW-1:0] byte_sh;
        logic [`ICACHE_DW-1:0] half_sh;
        byte_sh = word >> {offset, 3'b000};
        half_sh = word >> {offset[1], 4'b0000};    // Bit 0 ignored for halfword
        case (width)
            icache_pkg::WIDTH_BYTE: align_rdata = {{(`ICACHE_DW-8){1'b0}}, byte_sh[7:0]};
            icache_pkg::WIDTH_HALF: align_rdata = {{(`ICACHE_DW-16){1'b0}}, half_sh[15:0]};
            default:                align_rdata = word;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Handshake and lookup outputs
    // ------------------------------------------------------------------------
    assign cpu_req_ack_o  = cpu_req_valid_i && (state == S_IDLE);    // Same-cycle accept
    assign cmp_tag_o      = req_q.addr[`ICACHE_TAG_MSB:`ICACHE_TAG_LSB];

    // Miss in LOOKUP kicks the burst engine, line aligned
    assign refill_start_o = (state == S_LOOKUP) && !tag_hit_i;
    assign refill_addr_o  = {req_q.addr[`ICACHE_AW-1:`ICACHE_TAG_LSB], {`ICACHE_TAG_LSB{1'b0}}};

    // Hit reads straight from the matching line
    assign ram_rd_en_o    = (state == S_LOOKUP) && tag_hit_i;
    assign ram_rd_addr_o  = {tag_hindex_i, req_q.addr[`ICACHE_TAG_LSB-1:2]};

    assign cpu_rsp_o      = '{valid: rsp_valid_q, data: rsp_data_q};

    // ------------------------------------------------------------------------
    // Controller FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= (state == S_RESPOND);   // Exactly one cycle
            case (state)
                S_IDLE:    if (cpu_req_ack_o) state <= S_LOOKUP;
                S_LOOKUP:  state <= tag_hit_i ? S_READ : S_REFILL;
                S_REFILL:  if (refill_done_i) state <= S_LOOKUP;    // Second lookup now hits
                S_READ:    state <= S_RESPOND;
                S_RESPOND: state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    // Request latch and read data register
    always_ff @(posedge mclk) begin
        if (cpu_req_ack_o) begin
            req_q <= cpu_req_i;
        end
        if (state == S_READ) begin
            rsp_data_q <= align_rdata(req_q.width, req_q.addr[1:0], ram_rd_data_i);
        end
    end

endmodule

/* hw/icache_top.sv */
`include "icache_config.svh"

module icache_top (
    input  logic                 mclk,
    input  logic                 rst_n,

    // CPU fetch port
    input  logic                 cpu_req_valid_i,
    input  icache_pkg::cpu_req_t cpu_req_i,
    output logic                 cpu_req_ack_o,
    output icache_pkg::cpu_rsp_t cpu_rsp_o,

    // Burst memory bus
    output icache_pkg::wb_req_t  wb_req_o,
    input  icache_pkg::wb_rsp_t  wb_rsp_i
);

    logic [`ICACHE_TAG_W-1:0]  cmp_tag;        // Tag of latched request
    logic                      tag_hit;
    logic [`ICACHE_IDX_W-1:0]  tag_hindex;     // Line holding the hit
    logic [`ICACHE_IDX_W-1:0]  fifo_ptr;       // Next line to replace
    logic                      tag_wr;
    icache_pkg::tag_entry_t    tag_entry;

    logic                      refill_start;
    logic [`ICACHE_AW-1:0]     refill_addr;
    logic                      refill_done;

    logic                      ram_rd_en;
    logic [`ICACHE_RAM_AW-1:0] ram_rd_addr;
    logic [`ICACHE_DW-1:0]     ram_rd_data;
    icache_pkg::ram_wr_t       ram_wr;         // Refill write port

    icache_ctrl i_ctrl (
        .mclk            (mclk),
        .rst_n           (rst_n),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_req_i       (cpu_req_i),
        .cpu_req_ack_o   (cpu_req_ack_o),
        .cpu_rsp_o       (cpu_rsp_o),
        .cmp_tag_o       (cmp_tag),
        .tag_hit_i       (tag_hit),
        .tag_hindex_i    (tag_hindex),
        .refill_start_o  (refill_start),
        .refill_addr_o   (refill_addr),
        .refill_done_i   (refill_done),
        .ram_rd_en_o     (ram_rd_en),
        .ram_rd_addr_o   (ram_rd_addr),
        .ram_rd_data_i   (ram_rd_data)
    );

    icache_tag_store i_tag_store (
        .mclk       (mclk),
        .rst_n      (rst_n),
        .cmp_tag_i  (cmp_tag),
        .hit_o      (tag_hit),
        .hindex_o   (tag_hindex),
        .wr_i       (tag_wr),
        .wr_entry_i (tag_entry),
        .wr_ptr_o   (fifo_ptr)
    );

    icache_refill i_refill (
        .mclk        (mclk),
        .rst_n       (rst_n),
        .start_i     (refill_start),
        .line_addr_i (refill_addr),
        .wr_ptr_i    (fifo_ptr),
        .wb_req_o    (wb_req_o),
        .wb_rsp_i    (wb_rsp_i),
        .ram_wr_o    (ram_wr),
        .tag_wr_o    (tag_wr),
        .tag_entry_o (tag_entry),
        .done_o      (refill_done)
    );

    icache_data_ram i_data_ram (
        .mclk      (mclk),
        .wr_i      (ram_wr),
        .rd_en_i   (ram_rd_en),
        .rd_addr_i (ram_rd_addr),
        .rd_data_o (ram_rd_data)
    );

endmodule

/* verif/icache_checker.sv */
module icache_checker (
    input logic                 mclk,
    input logic                 rst_n,
    input logic                 cpu_req_valid_i,
    input logic                 cpu_req_ack_o,
    input icache_pkg::cpu_rsp_t cpu_rsp_o,
    input icache_pkg::wb_req_t  wb_req_o,
    input icache_pkg::wb_rsp_t  wb_rsp_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int stb_fails;
    int rsp_fails;
    int ack_fails;
    int assertion_fails;                     // Read by the testbench summary

    assign assertion_fails = stb_fails + rsp_fails + ack_fails;

    // ------------------------------------------------------------------------
    // Bus and CPU handshakes
    // ------------------------------------------------------------------------
    stb_hold: assert property (@(posedge mclk) disable iff (!rst_n)
        wb_req_o.stb && !(wb_rsp_i.ack && wb_rsp_i.lack) |=> wb_req_o.stb)
        else begin
            $error("strobe fell before the last ack");
            stb_fails++;
        end

    // Response pulse is a single cycle
    rsp_pulse: assert property (@(posedge mclk) disable iff (!rst_n)
        cpu_rsp_o.valid |=> !cpu_rsp_o.valid)
        else begin
            $error("response valid held longer than one cycle");
            rsp_fails++;
        end

    ack_needs_req: assert property (@(posedge mclk) disable iff (!rst_n)
        cpu_req_ack_o |-> cpu_req_valid_i)
        else begin
            $error("request ack without request valid");
            ack_fails++;
        end

endmodule

bind icache_top icache_checker i_checker (
    .mclk            (mclk),
    .rst_n           (rst_n),
    .cpu_req_valid_i (cpu_req_valid_i),
    .cpu_req_ack_o   (cpu_req_ack_o),
    .cpu_rsp_o       (cpu_rsp_o),
    .wb_req_o        (wb_req_o),
    .wb_rsp_i        (wb_rsp_i)
);

/* verif/icache_tb.sv */
`include "icache_config.svh"

module icache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 20;
    localparam int CYCLES_PER_TEST = 200;    // Watchdog budget per test line
    localparam int HIT_EDGES       = 3;      // Accept edge to response pulse

    logic                 mclk;
    logic                 rst_n;
    logic                 cpu_req_valid;
    icache_pkg::cpu_req_t cpu_req;
    logic                 cpu_req_ack;
    icache_pkg::cpu_rsp_t cpu_rsp;
    icache_pkg::wb_req_t  wb_req;
    icache_pkg::wb_rsp_t  wb_rsp;

    integer      seed = 32'h1c64c01d;        // Ack gap generator
    int          errors;
    int          mon_errors;                 // Found by the burst monitor
    int          bursts;                     // Strobe rises so far
    int          accept_cnt;                 // Accepting edges so far
    int          beat;
    int          gap;
    int          n_tests;
    bit          loaded;
    logic        stb_prev;
    logic [31:0] line_base;                  // Expected burst address

    // Test vectors
    logic [31:0] t_addr [$];
    logic [1:0]  t_width [$];
    logic [31:0] t_data [$];
    logic        t_miss [$];

    icache_top i_dut (
        .mclk            (mclk),
        .rst_n           (rst_n),
        .cpu_req_valid_i (cpu_req_valid),
        .cpu_req_i       (cpu_req),
        .cpu_req_ack_o   (cpu_req_ack),
        .cpu_rsp_o       (cpu_rsp),
        .wb_req_o        (wb_req),
        .wb_rsp_i        (wb_rsp)
    );

    initial begin
        mclk = 1'b0;
        forever #(CLK_PERIOD / 2) mclk = ~mclk;
    end

    // Upper half is the word address, lower half its inverse
    function automatic logic [31:0] model_word(input logic [29:0] waddr);
        return {waddr[15:0], ~waddr[15:0]};
    endfunction

    // ------------------------------------------------------------------------
    // Burst memory model and bus monitor
    // ------------------------------------------------------------------------
    initial begin
        wb_rsp = '0;
        gap    = 0;
        forever begin
            @(negedge mclk);
            wb_rsp.ack  = 1'b0;
            wb_rsp.lack = 1'b0;
            if (!wb_req.stb) begin
                beat = 0;                                   // Ready for next burst
            end else if (beat < `ICACHE_LINE_WORDS) begin
                if (gap > 0) begin
                    gap--;                                  // Idle cycle between acks
                end else begin
                    wb_rsp.ack  = 1'b1;
                    wb_rsp.lack = (beat == `ICACHE_LINE_WORDS - 1);
                    wb_rsp.dat  = model_word(wb_req.adr[31:2] + 30'(beat));
                    beat++;
                    gap = {$random(seed)} % 3;              // 0 to 2 cycles
                end
            end
        end
    end

    initial begin
        stb_prev = 1'b0;
        forever begin
            @(negedge mclk);
            if (wb_req.stb && !stb_prev) begin              // New burst
                bursts++;
                if (wb_req.adr !== line_base) begin
                    mon_errors++;
                    $display("error: wb_req_o.adr got 0x%08h expected 0x%08h",
                             wb_req.adr, line_base);
                end
                if (wb_req.bl !== 10'd32) begin             // One full line per burst
                    mon_errors++;
                    $display("error: wb_req_o.bl got 0x%03h expected 0x%03h",
                             wb_req.bl, 10'd32);
                end
            end
            stb_prev = wb_req.stb;
        end
    end

    always @(posedge mclk) begin
        if (cpu_req_ack) accept_cnt <= accept_cnt + 1;     // Transfer at this edge
    end

    // ------------------------------------------------------------------------
    // Tests file and read sequence
    // ------------------------------------------------------------------------
    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] d;
        logic [31:0] m;
        fd = $fopen("verif/icache_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/icache_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin    // Skip notes and blanks
                    n = $sscanf(line, "%h %h %h %h", a, w, d, m);
                    if (n == 4) begin
                        t_addr.push_back(a);
                        t_width.push_back(w[1:0]);
                        t_data.push_back(d);
                        t_miss.push_back(m[0]);
                    end else begin
                        errors++;
                        $display("test line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        n_tests = t_addr.size();
        if (n_tests == 0) begin
            errors++;
            $display("no test lines were read");
        end
        loaded = 1'b1;
    endtask

    task automatic issue_read(input int idx);
        int cycles;
        int acc_base;
        int burst_base;
        @(negedge mclk);
        acc_base      = accept_cnt;
        burst_base    = bursts;
        line_base     = {t_addr[idx][31:7], 7'b0};
        cpu_req_valid = 1'b1;
        cpu_req       = '{addr: t_addr[idx], width: icache_pkg::width_e'(t_width[idx])};
        @(negedge mclk);
        while (accept_cnt == acc_base) @(negedge mclk);     // Held until accepted
        cpu_req_valid = 1'b0;
        cycles        = 0;
        while (!cpu_rsp.valid) begin
            @(negedge mclk);
            cycles++;
        end
        if (cpu_rsp.data !== t_data[idx]) begin
            errors++;
            $display("error: cpu_rsp_o.data at 0x%08h got 0x%08h expected 0x%08h",
                     t_addr[idx], cpu_rsp.data, t_data[idx]);
        end
        if ((bursts - burst_base) != int'(t_miss[idx])) begin
            errors++;
            $display("read at %08h made %0d bursts instead of %0d",
                     t_addr[idx], bursts - burst_base, t_miss[idx]);
        end
        if (!t_miss[idx] && cycles != HIT_EDGES) begin
            errors++;
            $display("hit at %08h answered %0d edges after accept instead of %0d",
                     t_addr[idx], cycles, HIT_EDGES);
        end
    endtask

    initial begin
        wait (loaded);
        repeat (CYCLES_PER_TEST * (n_tests + 1)) @(posedge mclk);
        $display("timeout after %0d cycles, reads did not complete",
                 CYCLES_PER_TEST * (n_tests + 1));
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int total;
        rst_n         = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        line_base     = '0;
        load_tests();
        repeat (4) @(posedge mclk);
        @(negedge mclk);
        rst_n = 1'b1;
        @(negedge mclk);
        if (cpu_req_ack !== 1'b0 || cpu_rsp.valid !== 1'b0 || wb_req.stb !== 1'b0) begin
            errors++;
            $display("error: ack 0x%0h rsp valid 0x%0h stb 0x%0h after reset expected 0x0",
                     cpu_req_ack, cpu_rsp.valid, wb_req.stb);
        end
        for (int i = 0; i < n_tests; i++) begin
            issue_read(i);
        end
        repeat (2) @(negedge mclk);
        total = errors + mon_errors + i_dut.i_checker.assertion_fails;
        $display("reads %0d bursts %0d errors %0d", n_tests, bursts, total);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verif/icache_tests.txt */
# address  width  data  miss (hex columns)
# width 0 byte, 1 half, 2 word; data right-aligned; miss 1 when one burst is expected
00001000 2 0400fbff 1
00001004 2 0401fbfe 0
00001008 0 000000fd 0
00001009 0 000000fb 0
0000100a 0 00000002 0
0000100b 0 00000004 0
00001008 1 0000fbfd 0
0000100a 1 00000402 0
0000107c 2 041ffbe0 0
00001084 2 0421fbde 1
00001108 2 0442fbbd 1
0000118c 2 0463fb9c 1
00001210 2 0484fb7b 1
00001294 2 04a5fb5a 1
00001318 2 04c6fb39 1
0000139c 2 04e7fb18 1
00001420 2 0508faf7 1
000014a4 2 0529fad6 1
00001528 2 054afab5 1
000015ac 2 056bfa94 1
00001630 2 058cfa73 1
000016b4 2 05adfa52 1
00001738 2 05cefa31 1
000017bc 2 05effa10 1
00001840 2 0610f9ef 1
00001000 2 0400fbff 1
00001108 2 0442fbbd 0
00001084 2 0421fbde 1
00001842 1 00000610 0

/* verilog.f */
+incdir+hw
hw/icache_pkg.sv
hw/icache_data_ram.sv
hw/icache_tag_store.sv
hw/icache_refill.sv
hw/icache_ctrl.sv
hw/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv

/* Makefile */
SRC := $(wildcard hw/*.sv hw/*.svh verif/*.sv)

all: run

obj_dir/Vicache_tb: $(SRC) verilog.f
	verilator --binary --timing --assert --top-module icache_tb -f verilog.f -o Vicache_tb

run: obj_dir/Vicache_tb verif/icache_tests.txt
	./obj_dir/Vicache_tb +verilator+error+limit+100 | tee sim.log
	grep -q -F -x '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
